/* niuProgram.hex */
// One 32-bit instruction word per line, in hex, from address 0
// Fields: op1[31:27] rx[26:22] ry[21:17] imm[16:0] or rz[16:12] op2[4:0]
08030000  // 00 ADDI r1, r0, -65536   I/O base
08041234  // 01 ADDI r2, r0, 0x1234
98040020  // 02 SW   r2, 32(r0)       Data word 8
80060020  // 03 LW   r3, 32(r0)
98460000  // 04 SW   r3, 0x000(r1)    Display
08080155  // 05 ADDI r4, r0, 0x155
080A03FF  // 06 ADDI r5, r0, 0x3FF    Ten bit mask
080C0050  // 07 ADDI r6, r0, 0x50     Subroutine address
804E0120  // 08 LW   r7, 0x120(r1)    Loop top, read switches
F9BE0000  // 09 JAL  r31, r6
98500020  // 10 SW   r8, 0x020(r1)    Red LEDs
80520100  // 11 LW   r9, 0x100(r1)    Read keys
2A520001  // 12 ANDI r9, r9, 1
CA400003  // 13 BNE  r9, r0, +3
0814005A  // 14 ADDI r10, r0, 0x5A
98540040  // 15 SW   r10, 0x040(r1)   Green LEDs
C001FFF7  // 16 BEQ  r0, r0, -9       Back to loop top
081400A5  // 17 ADDI r10, r0, 0xA5
98540040  // 18 SW   r10, 0x040(r1)
C001FFF4  // 19 BEQ  r0, r0, -12
01C88007  // 20 XOR  r8, r7, r4       Subroutine
42100001  // 21 SULI r8, r8, 1
0A100003  // 22 ADDI r8, r8, 3
020A8005  // 23 AND  r8, r8, r5
FFC00000  // 24 JAL  r0, r31          Return

/* niuCore.f */
+incdir+.
niuPkg.sv
niuRegFile.sv
niuAlu.sv
niuDataMemory.sv
niuControl.sv
niuCore.sv
niuCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the niuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module niuCoreTb \
    -f niuCore.f -o niuCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/niuCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* niuCoreTb.sv */
module niuCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 4;
    localparam int numRounds   = 8;
    localparam int hexLimit    = 200;    // Startup code needs about 35 cycles
    localparam int settleLimit = 400;    // One loop pass stays under 100 cycles
    localparam int holdCycles  = 250;
    localparam int cycleLimit  = 20000;  // Well above startup plus all rounds

    logic        clk;
    logic        reset;
    logic [9:0]  switch;
    logic [3:0]  key;
    logic [15:0] hexValue;
    logic [9:0]  ledr;
    logic [7:0]  ledg;

    logic [9:0]  expLedr;
    logic [7:0]  expLedg;
    logic        settled;  // Inputs steady and LEDs already reached
    int          seed;
    int          cycleCount = 0;

    niuCore UUT (
        .clk(clk), .reset(reset), .switch(switch), .key(key),
        .hexValue(hexValue), .ledr(ledr), .ledg(ledg)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Red LED value the subroutine should produce
    function automatic logic [9:0] ledrFor(input logic [9:0] sw);
        logic [31:0] mixed;
        mixed = (({22'h0, sw} ^ 32'h155) << 1) + 32'd3;
        return mixed[9:0];
    endfunction

    function automatic logic [7:0] ledgFor(input logic [3:0] k);
        return k[0] ? 8'hA5 : 8'h5A;
    endfunction

    idleInReset: assert property (@(negedge clk)
        reset |-> (hexValue == 16'h0 && ledr == 10'h0 && ledg == 8'h0))
        else failRun($sformatf("[ERROR] in reset hexValue 0x%h ledr 0x%h ledg 0x%h",
            $sampled(hexValue), $sampled(ledr), $sampled(ledg)));

    // Display only ever shows the startup value
    hexOnlyGoal: assert property (@(posedge clk) disable iff (reset)
        hexValue == 16'h0 || hexValue == 16'h1234)
        else failRun($sformatf("[ERROR] hexValue: expected 0x1234, got 0x%h",
            $sampled(hexValue)));

    hexBeforeLeds: assert property (@(posedge clk) disable iff (reset)
        (ledr != 10'h0 || ledg != 8'h0) |-> hexValue == 16'h1234)
        else failRun($sformatf("[ERROR] hexValue: expected 0x1234 before LEDs, got 0x%h",
            $sampled(hexValue)));

    ledrSteady: assert property (@(posedge clk) disable iff (reset)
        settled |-> ledr == expLedr)
        else failRun($sformatf("[ERROR] ledr: expected 0x%h, got 0x%h",
            $sampled(expLedr), $sampled(ledr)));

    ledgSteady: assert property (@(posedge clk) disable iff (reset)
        settled |-> ledg == expLedg)
        else failRun($sformatf("[ERROR] ledg: expected 0x%h, got 0x%h",
            $sampled(expLedg), $sampled(ledg)));

    task automatic waitForHex();
        int waited;
        waited = 0;
        while (hexValue != 16'h1234 && waited < hexLimit) begin
            @(negedge clk);
            waited++;
        end
        hexReached: assert (hexValue == 16'h1234)
            else failRun($sformatf("[ERROR] hexValue: expected 0x1234, got 0x%h", hexValue));
    endtask

    task automatic waitForLeds();
        int waited;
        waited = 0;
        while ((ledr != expLedr || ledg != expLedg) && waited < settleLimit) begin
            @(negedge clk);
            waited++;
        end
        ledrReached: assert (ledr == expLedr)
            else failRun($sformatf("[ERROR] ledr: expected 0x%h, got 0x%h", expLedr, ledr));
        ledgReached: assert (ledg == expLedg)
            else failRun($sformatf("[ERROR] ledg: expected 0x%h, got 0x%h", expLedg, ledg));
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("Timeout: the run did not finish within %0d cycles", cycleLimit));
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [3:0]  newKey;
        reset   <= 1'b1;
        switch  <= '0;
        key     <= '0;
        settled = 1'b0;
        expLedr = '0;
        expLedg = '0;
        seed    = 32'h1dde;

        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);  // First clock edge out of reset
        @(negedge clk);
        afterReset: assert (hexValue == 16'h0 && ledr == 10'h0 && ledg == 8'h0)
            else failRun($sformatf("[ERROR] after reset hexValue 0x%h ledr 0x%h ledg 0x%h",
                hexValue, ledr, ledg));

        waitForHex();

        for (int roundIdx = 0; roundIdx < numRounds; roundIdx++) begin
            @(posedge clk);
            rnd     = $random(seed);
            newKey  = {rnd[15:13], roundIdx[0]};  // Alternate so both branch paths run
            settled = 1'b0;
            switch  <= rnd[9:0];
            key     <= newKey;
            expLedr = ledrFor(rnd[9:0]);
            expLedg = ledgFor(newKey);
            @(negedge clk);
            waitForLeds();
            settled = 1'b1;
            repeat (holdCycles) @(posedge clk);  // Watch for stray writes
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* niuCore.sv */
`include "niu_macros.svh"

module niuCore (
    input  logic        clk,
    input  logic        reset,
    input  logic [9:0]  switch,
    input  logic [3:0]  key,
    output logic [15:0] hexValue,
    output logic [9:0]  ledr,
    output logic [7:0]  ledg
);
    import niuPkg::*;

    localparam int imemIdxBits = $clog2(`IMEM_WORDS);

    controlWord ctrl;
    instrFields ir;
    ioOutputs   io;
    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] bus;
    logic [`WORD_SIZE-1:0] regData;
    logic [`WORD_SIZE-1:0] memData;
    logic [`WORD_SIZE-1:0] aluResult;
    logic [`WORD_SIZE-1:0] immExt;
    logic aluFlag;

    logic [`WORD_SIZE-1:0] imem [`IMEM_WORDS];

    initial $readmemh("niuProgram.hex", imem);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `PC_START;
            ir <= '0;
        end else begin
            if (ctrl.ldPc) begin
                pc <= bus;
            end else if (ctrl.incPc) begin
                pc <= pc + `INSTR_SIZE;
            end
            if (ctrl.ldIr) ir <= instrFields'(imem[pc[imemIdxBits+1:2]]);  // Old PC
        end
    end

    assign immExt = {{(`WORD_SIZE-`IMM_SIZE){ir.tail.imm[`IMM_SIZE-1]}}, ir.tail.imm};

    // One driver per cycle, picked by the control word
    always_comb begin
        case (ctrl.busSrc)
            BUS_PC:   bus = pc;
            BUS_REG:  bus = regData;
            BUS_MEM:  bus = memData;
            BUS_IMM:  bus = immExt;
            BUS_IMM4: bus = immExt * `INSTR_SIZE;  // Branch offset in bytes
            BUS_ALU:  bus = aluResult;
            default:  bus = '0;
        endcase
    end

    niuControl control (.clk(clk), .reset(reset), .instr(ir), .aluFlag(aluFlag), .ctrl(ctrl));

    niuRegFile regFile (.clk(clk), .ctrl(ctrl), .bus(bus), .regData(regData));

    niuAlu alu (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus),
        .aluResult(aluResult), .aluFlag(aluFlag)
    );

    niuDataMemory dataMemory (
        .clk(clk), .reset(reset), .ctrl(ctrl), .bus(bus),
        .switch(switch), .key(key), .memData(memData), .io(io)
    );

    assign hexValue = io.hexValue;
    assign ledr     = io.ledr;
    assign ledg     = io.ledg;

endmodule

/* niuControl.sv */
`include "niu_macros.svh"

module niuControl (
    input  logic               clk,
    input  logic               reset,
    input  niuPkg::instrFields instr,
    input  logic               aluFlag,
    output niuPkg::controlWord ctrl
);
    import niuPkg::*;

    ctrlState state;
    ctrlState nextState;
    aluFunc   execFunc;
    aluFunc   branchFunc;

    // Immediate opcodes reuse the function codes directly
    assign execFunc = (instr.op1 == OP_ALU) ? aluFunc'(instr.tail.alu.op2)
                                            : aluFunc'(instr.op1);

    always_comb begin
        case (instr.op1)
            OP_BNE:  branchFunc = FN_NEQ;
            OP_BLT:  branchFunc = FN_LT;
            OP_BLE:  branchFunc = FN_LEQ;
            default: branchFunc = FN_EQ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl      = '0;  // Nothing on the bus by default
        nextState = S_FETCH;
        case (state)
            S_FETCH: begin
                ctrl.ldIr  = 1'b1;
                ctrl.incPc = 1'b1;
                nextState  = S_DECODE;
            end
            S_DECODE: begin
                case (instr.op1)
                    OP_ALU:                     nextState = S_ALU_B_REG;
                    OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
                    OP_SULI, OP_SSLI, OP_SURI, OP_SSRI:
                                                nextState = S_ALU_B_IMM;
                    OP_LW, OP_SW:               nextState = S_MEM_BASE;
                    OP_BEQ, OP_BNE, OP_BLT, OP_BLE:
                                                nextState = S_BR_A;
                    OP_JAL:                     nextState = S_JAL_LINK;
                    default:                    nextState = S_FETCH;  // Unknown op skipped
                endcase
            end
            S_ALU_B_IMM, S_MEM_OFS: begin
                ctrl.busSrc = BUS_IMM;
                ctrl.ldB    = 1'b1;
                nextState   = (state == S_MEM_OFS) ? S_MEM_ADD : S_ALU_A;
            end
            S_ALU_B_REG, S_BR_B: begin
                ctrl.busSrc = BUS_REG;
                ctrl.regSel = instr.ry;
                ctrl.ldB    = 1'b1;
                nextState   = (state == S_BR_B) ? S_BR_CMP : S_ALU_A;
            end
            S_ALU_A, S_MEM_BASE, S_BR_A: begin
                ctrl.busSrc = BUS_REG;
                ctrl.regSel = instr.rx;
                ctrl.ldA    = 1'b1;
                case (state)
                    S_MEM_BASE: nextState = S_MEM_OFS;
                    S_BR_A:     nextState = S_BR_B;
                    default:    nextState = S_ALU_EXEC;
                endcase
            end
            S_ALU_EXEC: begin
                ctrl.aluSel = execFunc;
                nextState   = S_ALU_WB;
            end
            S_ALU_WB: begin
                ctrl.aluSel = execFunc;
                ctrl.busSrc = BUS_ALU;
                ctrl.wrReg  = 1'b1;
                // Register form writes rz, immediate form writes ry
                ctrl.regSel = (instr.op1 == OP_ALU) ? instr.tail.alu.rz : instr.ry;
            end
            S_MEM_ADD, S_BR_ADD: begin
                ctrl.aluSel = FN_ADD;
                nextState   = (state == S_BR_ADD) ? S_BR_LOAD : S_MEM_MAR;
            end
            S_MEM_MAR: begin
                ctrl.busSrc = BUS_ALU;
                ctrl.ldMar  = 1'b1;
                nextState   = (instr.op1 == OP_SW) ? S_SW_WR : S_LW_MDR;
            end
            S_LW_MDR: nextState = S_LW_WB;  // Wait for MDR
            S_LW_WB: begin
                ctrl.busSrc = BUS_MEM;
                ctrl.regSel = instr.ry;
                ctrl.wrReg  = 1'b1;
            end
            S_SW_WR: begin
                ctrl.busSrc = BUS_REG;
                ctrl.regSel = instr.ry;
                ctrl.wrMem  = 1'b1;
            end
            S_BR_CMP: begin
                ctrl.aluSel = branchFunc;
                nextState   = S_BR_DECIDE;
            end
            S_BR_DECIDE: begin
                ctrl.aluSel = branchFunc;  // Hold the compare
                nextState   = aluFlag ? S_BR_PC : S_FETCH;
            end
            S_BR_PC: begin
                ctrl.busSrc = BUS_PC;  // Already points past the branch
                ctrl.ldA    = 1'b1;
                nextState   = S_BR_IMM;
            end
            S_BR_IMM: begin
                ctrl.busSrc = BUS_IMM4;
                ctrl.ldB    = 1'b1;
                nextState   = S_BR_ADD;
            end
            S_BR_LOAD: begin
                ctrl.busSrc = BUS_ALU;
                ctrl.ldPc   = 1'b1;
            end
            S_JAL_LINK: begin
                ctrl.busSrc = BUS_PC;  // Return address
                ctrl.regSel = instr.ry;
                ctrl.wrReg  = 1'b1;
                nextState   = S_JAL_JUMP;
            end
            S_JAL_JUMP: begin
                ctrl.busSrc = BUS_REG;
                ctrl.regSel = instr.rx;
                ctrl.ldPc   = 1'b1;
            end
            default: nextState = S_FETCH;
        endcase
    end

endmodule

/* niuDataMemory.sv */
`include "niu_macros.svh"

module niuDataMemory (
    input  logic                   clk,
    input  logic                   reset,
    input  niuPkg::controlWord     ctrl,
    input  logic [`WORD_SIZE-1:0]  bus,
    input  logic [9:0]             switch,
    input  logic [3:0]             key,
    output logic [`WORD_SIZE-1:0]  memData,
    output niuPkg::ioOutputs       io
);
    import niuPkg::*;

    localparam int dmemIdxBits = $clog2(`DMEM_WORDS);

    logic [`WORD_SIZE-1:0] dmem [`DMEM_WORDS];
    logic [`WORD_SIZE-1:0] mar;
    logic [`WORD_SIZE-1:0] mdr;
    logic [dmemIdxBits-1:0] wordIdx;
    logic ioWrite;

    assign wordIdx = mar[dmemIdxBits+1:2];  // Byte address to word index
    assign ioWrite = (mar == `ADDR_HEX) || (mar == `ADDR_LEDR) || (mar == `ADDR_LEDG);
    assign memData = mdr;

    always_ff @(posedge clk) begin
        if (ctrl.wrMem && !ioWrite) begin
            dmem[wordIdx] <= bus;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mar <= '0;
            mdr <= '0;
            io  <= '0;
        end else begin
            if (ctrl.ldMar) mar <= bus;

            if (ctrl.wrMem) begin
                case (mar)
                    `ADDR_HEX:  io.hexValue <= bus[15:0];
                    `ADDR_LEDR: io.ledr     <= bus[9:0];
                    `ADDR_LEDG: io.ledg     <= bus[7:0];
                    default:    ;  // Plain memory word
                endcase
            end

            // MDR trails MAR by one cycle
            if (mar == `ADDR_KEY) begin
                mdr <= {{(`WORD_SIZE-4){1'b0}}, key};
            end else if (mar == `ADDR_SWITCH) begin
                mdr <= {{(`WORD_SIZE-10){1'b0}}, switch};
            end else begin
                mdr <= dmem[wordIdx];
            end
        end
    end

endmodule

/* niuAlu.sv */
`include "niu_macros.svh"

module niuAlu (
    input  logic                   clk,
    input  logic                   reset,
    input  niuPkg::controlWord     ctrl,
    input  logic [`WORD_SIZE-1:0]  bus,
    output logic [`WORD_SIZE-1:0]  aluResult,
    output logic                   aluFlag
);
    import niuPkg::*;

    logic [`WORD_SIZE-1:0] opA;
    logic [`WORD_SIZE-1:0] opB;
    logic [`WORD_SIZE-1:0] nextResult;
    logic [$clog2(`WORD_SIZE)-1:0] shamt;

    assign shamt = opB[$clog2(`WORD_SIZE)-1:0];  // Only low bits count for shifts

    always_comb begin
        case (ctrl.aluSel)
            FN_SUB:  nextResult = opA - opB;
            FN_ADD:  nextResult = opA + opB;
            FN_NOT:  nextResult = ~opA;
            FN_AND:  nextResult = opA & opB;
            FN_OR:   nextResult = opA | opB;
            FN_XOR:  nextResult = opA ^ opB;
            FN_SUL:  nextResult = opA << shamt;
            FN_SSL:  nextResult = opA <<< shamt;
            FN_SUR:  nextResult = opA >> shamt;
            FN_SSR:  nextResult = $signed(opA) >>> shamt;  // Sign fill
            FN_EQ:   nextResult = `WORD_SIZE'(opA == opB);
            FN_NEQ:  nextResult = `WORD_SIZE'(opA != opB);
            FN_LT:   nextResult = `WORD_SIZE'(opA < opB);
            FN_LEQ:  nextResult = `WORD_SIZE'(opA <= opB);
            default: nextResult = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opA       <= '0;
            opB       <= '0;
            aluResult <= '0;
        end else begin
            if (ctrl.ldA) opA <= bus;
            if (ctrl.ldB) opB <= bus;
            aluResult <= nextResult;  // Free running
        end
    end

    // Compares leave 0 or 1, so bit 0 decides a branch
    assign aluFlag = aluResult[0];

endmodule

/* niuRegFile.sv */
`include "niu_macros.svh"

module niuRegFile (
    input  logic                   clk,
    input  niuPkg::controlWord     ctrl,
    input  logic [`WORD_SIZE-1:0]  bus,
    output logic [`WORD_SIZE-1:0]  regData
);
    import niuPkg::*;

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    // Register 0 is never written
    always_ff @(posedge clk) begin
        if (ctrl.wrReg && (ctrl.regSel != '0)) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // Zero base without clearing the array
    always_comb begin
        if (ctrl.regSel == '0) begin
            regData = '0;
        end else begin
            regData = regs[ctrl.regSel];
        end
    end

endmodule

/* niuPkg.sv */
`include "niu_macros.svh"

package niuPkg;

    typedef enum logic [`OP_BITS-1:0] {
        OP_ALU  = 5'b00000,  // Register form, function in op2
        OP_ADDI = 5'b00001,
        OP_ANDI = 5'b00101,
        OP_ORI  = 5'b00110,
        OP_XORI = 5'b00111,
        OP_SULI = 5'b01000,
        OP_SSLI = 5'b01001,
        OP_SURI = 5'b01010,
        OP_SSRI = 5'b01011,
        OP_LW   = 5'b10000,
        OP_SW   = 5'b10011,
        OP_BEQ  = 5'b11000,
        OP_BNE  = 5'b11001,
        OP_BLT  = 5'b11010,
        OP_BLE  = 5'b11011,
        OP_JAL  = 5'b11111
    } primaryOp;

    // Immediate opcodes share their code with the matching function
    typedef enum logic [`OP_BITS-1:0] {
        FN_SUB = 5'b00000,
        FN_ADD = 5'b00001,
        FN_NOT = 5'b00100,
        FN_AND = 5'b00101,
        FN_OR  = 5'b00110,
        FN_XOR = 5'b00111,
        FN_SUL = 5'b01000,
        FN_SSL = 5'b01001,
        FN_SUR = 5'b01010,
        FN_SSR = 5'b01011,
        FN_EQ  = 5'b10000,
        FN_NEQ = 5'b10001,
        FN_LT  = 5'b10010,
        FN_LEQ = 5'b10011
    } aluFunc;

    typedef enum logic [2:0] {
        BUS_NONE,
        BUS_PC,
        BUS_REG,
        BUS_MEM,
        BUS_IMM,
        BUS_IMM4,  // Immediate times instruction size
        BUS_ALU
    } busSource;

    typedef enum logic [4:0] {
        S_FETCH, S_DECODE,
        S_ALU_B_IMM, S_ALU_B_REG, S_ALU_A, S_ALU_EXEC, S_ALU_WB,
        S_MEM_BASE, S_MEM_OFS, S_MEM_ADD, S_MEM_MAR,
        S_LW_MDR, S_LW_WB, S_SW_WR,
        S_BR_A, S_BR_B, S_BR_CMP, S_BR_DECIDE,
        S_BR_PC, S_BR_IMM, S_BR_ADD, S_BR_LOAD,
        S_JAL_LINK, S_JAL_JUMP
    } ctrlState;

    // Low 17 bits seen as rz / unused / op2 in the register form
    typedef struct packed {
        logic [`REG_BITS-1:0]                    rz;
        logic [`IMM_SIZE-`REG_BITS-`OP_BITS-1:0] spare;
        logic [`OP_BITS-1:0]                     op2;
    } aluTail;

    typedef union packed {
        logic [`IMM_SIZE-1:0] imm;
        aluTail               alu;
    } instrTail;

    typedef struct packed {
        primaryOp             op1;   // Bits 31:27
        logic [`REG_BITS-1:0] rx;    // Bits 26:22
        logic [`REG_BITS-1:0] ry;    // Bits 21:17
        instrTail             tail;  // Bits 16:0
    } instrFields;

    typedef struct packed {
        logic                 ldPc;
        logic                 incPc;
        logic                 ldIr;
        logic                 wrReg;
        logic [`REG_BITS-1:0] regSel;
        logic                 ldA;
        logic                 ldB;
        aluFunc               aluSel;
        logic                 ldMar;
        logic                 wrMem;
        busSource             busSrc;
    } controlWord;

    typedef struct packed {
        logic [15:0] hexValue;
        logic [9:0]  ledr;
        logic [7:0]  ledg;
    } ioOutputs;

endpackage

/* niu_macros.svh */
`ifndef NIU_MACROS_SVH
`define NIU_MACROS_SVH

// Datapath sizing
`define WORD_SIZE   32
`define NUM_REGS    32
`define REG_BITS    5
`define OP_BITS     5
`define IMM_SIZE    17
`define INSTR_SIZE  4            // Bytes per instruction, PC step

// Memory depths in words
`define IMEM_WORDS  2048
`define DMEM_WORDS  2048

`define PC_START    32'h0000_0000

// Memory-mapped outputs
`define ADDR_HEX    32'hFFFF_0000
`define ADDR_LEDR   32'hFFFF_0020
`define ADDR_LEDG   32'hFFFF_0040

// Memory-mapped inputs, read only
`define ADDR_KEY    32'hFFFF_0100
`define ADDR_SWITCH 32'hFFFF_0120

`endif
